// File: lcdPkg.sv
`default_nettype none

package lcdPkg;

	// HD44780 instruction bytes, written with RS low
	localparam logic [7:0] CMD_FUNCSET = 8'h38; // 8-bit bus, 2 lines, 5x7 font
	localparam logic [7:0] CMD_DISPON  = 8'h0C; // display on, cursor off
	localparam logic [7:0] CMD_ENTRY   = 8'h06; // increment address, no shift
	localparam logic [7:0] CMD_CLEAR   = 8'h01; // clear display, home cursor
	localparam logic [7:0] CMD_LINE1   = 8'h80; // ddram address 0x00
	localparam logic [7:0] CMD_LINE2   = 8'hC0; // ddram address 0x40

	// panel geometry and write sequence lengths
	localparam int LINE_CHARS   = 16; // 16x2 panel
	localparam int INIT_STEPS   = 4;  // power-up configuration, ends on clear
	localparam int SCREEN_STEPS = 35; // clear, addr, 16 chars, addr, 16 chars

	// screen numbers held in CTRL[2:0]
	localparam logic [2:0] SCR_WELCOME  = 3'd0;
	localparam logic [2:0] SCR_SELSIG   = 3'd1;
	localparam logic [2:0] SCR_SIGDONE  = 3'd2;
	localparam logic [2:0] SCR_SELFREQ  = 3'd3;
	localparam logic [2:0] SCR_FREQDONE = 3'd4;
	localparam logic [2:0] SCR_RUN      = 3'd5;

	// APB register offsets
	localparam logic [7:0] ADDR_CTRL   = 8'h00; // screenId, waveSel
	localparam logic [7:0] ADDR_DIGITS = 8'h04; // three digits + multiplier

endpackage

`default_nettype wire

// File: lcdApbRegs.sv
`default_nettype none

module lcdApbRegs (
	input wire clk_1MHz,
	input wire rstN,
	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [7:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// register contents towards the text table
	output logic [2:0] screenId,
	output logic [2:0] waveSel,
	output logic [7:0] digit0,
	output logic [7:0] digit1,
	output logic [7:0] digit2,
	output logic [7:0] multiplier,
	output logic redrawReq
);

	logic access; // second cycle of a transfer
	logic ctrlHit;
	logic digitsHit;
	logic wrEn;

	assign access = psel & penable;
	assign ctrlHit = (paddr == lcdPkg::ADDR_CTRL);
	assign digitsHit = (paddr == lcdPkg::ADDR_DIGITS);
	assign wrEn = access & pwrite;

	assign pready = 1'b1; // no wait states
	assign pslverr = access & ~(ctrlHit | digitsHit); // unmapped offset

	// read mux, unmapped offsets return zero
	always_comb begin
		prdata = 32'h0;
		if (ctrlHit) begin
			prdata = {25'h0, waveSel, 1'b0, screenId};
		end else if (digitsHit) begin
			prdata = {multiplier, digit2, digit1, digit0};
		end
	end

	always_ff @(posedge clk_1MHz) begin
		if (!rstN) begin
			screenId <= lcdPkg::SCR_WELCOME;
			waveSel <= 3'd0;
			digit0 <= 8'h20; // readout starts blank
			digit1 <= 8'h20;
			digit2 <= 8'h20;
			multiplier <= 8'h20;
			redrawReq <= 1'b0;
		end else begin
			redrawReq <= wrEn & ctrlHit; // one cycle after the CTRL access
			if (wrEn && ctrlHit) begin
				screenId <= pwdata[2:0];
				waveSel <= pwdata[6:4];
			end
			if (wrEn && digitsHit) begin
				digit0 <= pwdata[7:0];
				digit1 <= pwdata[15:8];
				digit2 <= pwdata[23:16];
				multiplier <= pwdata[31:24];
			end
		end
	end

endmodule

`default_nettype wire

// File: lcdScreenText.sv
`default_nettype none

module lcdScreenText (
	input wire [5:0] step,
	input wire [2:0] screenId,
	input wire [2:0] waveSel,
	input wire [7:0] digit0,
	input wire [7:0] digit1,
	input wire [7:0] digit2,
	input wire [7:0] multiplier,
	output logic [7:0] stepByte,
	output logic stepIsData
);

	localparam int textW = lcdPkg::LINE_CHARS * 8; // one line of text, column 0 in msb
	localparam int colW = $clog2(lcdPkg::LINE_CHARS);

	// step map of the write sequence
	localparam logic [5:0] clearStep = 6'(lcdPkg::INIT_STEPS);
	localparam logic [5:0] line1Addr = 6'(lcdPkg::INIT_STEPS + 1);
	localparam logic [5:0] line1First = 6'(lcdPkg::INIT_STEPS + 2);
	localparam logic [5:0] line2Addr = 6'(lcdPkg::INIT_STEPS + 2 + lcdPkg::LINE_CHARS);
	localparam logic [5:0] line2First = 6'(lcdPkg::INIT_STEPS + 3 + lcdPkg::LINE_CHARS);
	localparam logic [5:0] lastStep = 6'(lcdPkg::INIT_STEPS + lcdPkg::SCREEN_STEPS - 1);

	// fixed screen text, padded with spaces
	localparam logic [textW-1:0] txtBlank = {lcdPkg::LINE_CHARS{8'h20}};
	localparam logic [textW-1:0] txtWelcome1 = {{4{8'h20}}, "Waveform", {4{8'h20}}};
	localparam logic [textW-1:0] txtWelcome2 = {{3{8'h20}}, "Generator!", {3{8'h20}}};
	localparam logic [textW-1:0] txtSelSig = {"Select Signal", {3{8'h20}}};
	localparam logic [textW-1:0] txtSigDone = {"Selected Signal", 8'h20};
	localparam logic [textW-1:0] txtSelFreq = "Select Frequency";
	localparam logic [textW-1:0] txtFreqDone = "Selected Freq...";
	localparam logic [textW-1:0] txtRun = {"Generating...", {3{8'h20}}};

	// waveform names for waveSel 1 to 6
	localparam logic [textW-1:0] txtSine = {"Sine", {12{8'h20}}};
	localparam logic [textW-1:0] txtCosine = {"Cosine", {10{8'h20}}};
	localparam logic [textW-1:0] txtTriangular = {"Triangular", {6{8'h20}}};
	localparam logic [textW-1:0] txtSinc = {"Sinc", {12{8'h20}}};
	localparam logic [textW-1:0] txtSawtooth = {"Sawtooth", {8{8'h20}}};
	localparam logic [textW-1:0] txtSquare = {"Square", {10{8'h20}}};

	logic [textW-1:0] line1Text;
	logic [textW-1:0] line2Text;
	logic [textW-1:0] waveText;
	logic [textW-1:0] readoutText; // digits and multiplier only
	logic [textW-1:0] readoutHzText; // same, followed by Hz
	logic [colW-1:0] col1;
	logic [colW-1:0] col2;

	function automatic logic [7:0] charAt(input logic [textW-1:0] text,
		input logic [colW-1:0] col);
		charAt = text[(lcdPkg::LINE_CHARS - 1 - col) * 8 +: 8];
	endfunction

	assign readoutText = {digit0, digit1, digit2, 8'h20, multiplier, {11{8'h20}}};
	assign readoutHzText = {digit0, digit1, digit2, 8'h20, multiplier, "Hz", {9{8'h20}}};

	always_comb begin
		case (waveSel)
			3'd1: waveText = txtSine;
			3'd2: waveText = txtCosine;
			3'd3: waveText = txtTriangular;
			3'd4: waveText = txtSinc;
			3'd5: waveText = txtSawtooth;
			3'd6: waveText = txtSquare;
			default: waveText = txtBlank; // 0 and 7 show nothing
		endcase
	end

	// pick both lines for the current screen
	always_comb begin
		case (screenId)
			lcdPkg::SCR_SELSIG: begin
				line1Text = txtSelSig;
				line2Text = txtBlank;
			end
			lcdPkg::SCR_SIGDONE: begin
				line1Text = txtSigDone;
				line2Text = waveText;
			end
			lcdPkg::SCR_SELFREQ: begin
				line1Text = txtSelFreq;
				line2Text = readoutText;
			end
			lcdPkg::SCR_FREQDONE: begin
				line1Text = txtFreqDone;
				line2Text = readoutHzText;
			end
			lcdPkg::SCR_RUN: begin
				line1Text = txtRun;
				line2Text = readoutHzText;
			end
			default: begin // welcome, also ids 6 and 7
				line1Text = txtWelcome1;
				line2Text = txtWelcome2;
			end
		endcase
	end

	assign col1 = colW'(step - line1First);
	assign col2 = colW'(step - line2First);

	// step to byte and RS
	always_comb begin
		stepByte = lcdPkg::CMD_LINE1; // unused steps
		stepIsData = 1'b0;
		if (step == 6'd0) begin
			stepByte = lcdPkg::CMD_FUNCSET;
		end else if (step == 6'd1) begin
			stepByte = lcdPkg::CMD_DISPON;
		end else if (step == 6'd2) begin
			stepByte = lcdPkg::CMD_ENTRY;
		end else if (step == 6'd3 || step == clearStep) begin
			stepByte = lcdPkg::CMD_CLEAR; // last config command, redraw entry
		end else if (step == line1Addr) begin
			stepByte = lcdPkg::CMD_LINE1;
		end else if (step >= line1First && step < line2Addr) begin
			stepByte = charAt(line1Text, col1);
			stepIsData = 1'b1;
		end else if (step == line2Addr) begin
			stepByte = lcdPkg::CMD_LINE2;
		end else if (step >= line2First && step <= lastStep) begin
			stepByte = charAt(line2Text, col2);
			stepIsData = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: lcdWriteSeq.sv
`default_nettype none

module lcdWriteSeq #(
	parameter int ePulseCycles = 2, // E high time
	parameter int eGapCycles = 50, // E low time between bytes
	parameter int clearWaitCycles = 2000 // E low time after a clear
) (
	input wire clk_1MHz,
	input wire rstN,
	input wire redrawReq,
	input wire [7:0] stepByte,
	input wire stepIsData,
	output logic [5:0] step,
	output logic [7:0] lcdData,
	output logic lcdRs,
	output logic lcdE
);

	localparam int pulseGapMax = (ePulseCycles > eGapCycles) ? ePulseCycles : eGapCycles;
	localparam int cntMax = (clearWaitCycles > pulseGapMax) ? clearWaitCycles : pulseGapMax;
	localparam int cntW = $clog2(cntMax + 1);

	localparam logic [cntW-1:0] pulseLast = cntW'(ePulseCycles - 1);
	localparam logic [cntW-1:0] gapLast = cntW'(eGapCycles - 1);
	localparam logic [cntW-1:0] clearLast = cntW'(clearWaitCycles - 1);

	localparam logic [5:0] initLast = 6'(lcdPkg::INIT_STEPS - 1); // config ends on clear
	localparam logic [5:0] clearStep = 6'(lcdPkg::INIT_STEPS);
	localparam logic [5:0] loopStep = 6'(lcdPkg::INIT_STEPS + 1); // line 1 address
	localparam logic [5:0] lastStep = 6'(lcdPkg::INIT_STEPS + lcdPkg::SCREEN_STEPS - 1);

	logic [cntW-1:0] cnt; // phase counter
	logic [5:0] stepReg; // next step to write
	logic [5:0] nextStep;
	logic [cntW-1:0] lowLast;
	logic clearByte; // byte on the bus is a clear
	logic redrawPending;
	logic redrawWant;
	logic jumpToClear;
	logic byteStart;

	assign redrawWant = redrawPending | redrawReq;
	assign jumpToClear = redrawWant & (stepReg >= clearStep); // held off during init
	assign step = jumpToClear ? clearStep : stepReg;

	assign lowLast = clearByte ? clearLast : gapLast; // settle after clear
	assign byteStart = ~lcdE & (cnt == lowLast); // end of low phase

	// after init and after line 2, loop back to line 1 address
	assign nextStep = (step == initLast || step == lastStep) ? loopStep : step + 6'd1;

	always_ff @(posedge clk_1MHz) begin
		if (!rstN) begin
			stepReg <= 6'd0;
			cnt <= '0;
			lcdE <= 1'b0;
			lcdData <= 8'h00;
			lcdRs <= 1'b0;
			clearByte <= 1'b0;
			redrawPending <= 1'b0;
		end else begin
			redrawPending <= redrawWant & ~(byteStart & jumpToClear); // keep until taken
			if (lcdE) begin
				if (cnt == pulseLast) begin
					lcdE <= 1'b0; // falling edge latches the panel
					cnt <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (byteStart) begin
				lcdE <= 1'b1;
				cnt <= '0;
				lcdData <= stepByte; // held for the whole byte
				lcdRs <= stepIsData;
				clearByte <= ~stepIsData & (stepByte == lcdPkg::CMD_CLEAR);
				stepReg <= nextStep;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: lcdTop.sv
`default_nettype none

module lcdTop #(
	parameter int ePulseCycles = 2, // 2 us at 1 MHz
	parameter int eGapCycles = 50, // covers 37 us instruction time
	parameter int clearWaitCycles = 2000 // clear needs about 1.5 ms
) (
	input wire clk_1MHz,
	input wire rstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [7:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [7:0] lcdData,
	output logic lcdRs,
	output logic lcdE
);

	logic [2:0] screenId;
	logic [2:0] waveSel;
	logic [7:0] digit0;
	logic [7:0] digit1;
	logic [7:0] digit2;
	logic [7:0] multiplier;
	logic redrawReq;
	logic [5:0] step;
	logic [7:0] stepByte;
	logic stepIsData;

	lcdApbRegs lcdApbRegs_inst (
		.clk_1MHz(clk_1MHz),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.screenId(screenId),
		.waveSel(waveSel),
		.digit0(digit0),
		.digit1(digit1),
		.digit2(digit2),
		.multiplier(multiplier),
		.redrawReq(redrawReq)
	);

	lcdScreenText lcdScreenText_inst (
		.step(step),
		.screenId(screenId),
		.waveSel(waveSel),
		.digit0(digit0),
		.digit1(digit1),
		.digit2(digit2),
		.multiplier(multiplier),
		.stepByte(stepByte),
		.stepIsData(stepIsData)
	);

	lcdWriteSeq #(
		.ePulseCycles(ePulseCycles),
		.eGapCycles(eGapCycles),
		.clearWaitCycles(clearWaitCycles)
	) lcdWriteSeq_inst (
		.clk_1MHz(clk_1MHz),
		.rstN(rstN),
		.redrawReq(redrawReq),
		.stepByte(stepByte),
		.stepIsData(stepIsData),
		.step(step),
		.lcdData(lcdData),
		.lcdRs(lcdRs),
		.lcdE(lcdE)
	);

endmodule

`default_nettype wire

// File: tbLcdProps.sv
`default_nettype none

module tbLcdProps #(
	parameter int ePulseCycles = 4
) (
	input wire clk_1MHz,
	input wire rstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [7:0] paddr,
	input wire redrawReq,
	input wire [7:0] lcdData,
	input wire lcdRs,
	input wire lcdE
);
	timeunit 1ns;
	timeprecision 1ps;

	int hiCount; // cycles lcdE has been high
	int failCount = 0; // assertion failures so far

	always_ff @(posedge clk_1MHz) begin
		if (!rstN || !lcdE) begin
			hiCount <= 0;
		end else begin
			hiCount <= hiCount + 1;
		end
	end

	pRedrawAfterCtrl: assert property (@(posedge clk_1MHz) disable iff (!rstN)
		(psel && penable && pwrite && (paddr == lcdPkg::ADDR_CTRL)) |=> redrawReq)
		else begin
			$error("no redrawReq in the cycle after a CTRL write");
			failCount++;
		end

	pRedrawOneCycle: assert property (@(posedge clk_1MHz) disable iff (!rstN)
		redrawReq |=> !redrawReq)
		else begin
			$error("redrawReq high for two cycles");
			failCount++;
		end

	pStrobeWidth: assert property (@(posedge clk_1MHz) disable iff (!rstN)
		$fell(lcdE) |-> (hiCount == ePulseCycles))
		else begin
			$error("lcdE high phase has wrong length");
			failCount++;
		end

	pBusStable: assert property (@(posedge clk_1MHz) disable iff (!rstN)
		(lcdE && $past(lcdE)) |-> ($stable(lcdData) && $stable(lcdRs)))
		else begin
			$error("lcdData or lcdRs changed while lcdE high");
			failCount++;
		end

endmodule

bind lcdTop tbLcdProps #(.ePulseCycles(ePulseCycles)) tbLcdProps_inst (
	.clk_1MHz(clk_1MHz),
	.rstN(rstN),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.redrawReq(redrawReq),
	.lcdData(lcdData),
	.lcdRs(lcdRs),
	.lcdE(lcdE)
);

`default_nettype wire

// File: tbLcd.sv
`default_nettype none

module tbLcd;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk_1MHz;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;
	wire [7:0] lcdData;
	wire lcdRs;
	wire lcdE;

	int cycles = 0; // timeout counter
	logic [31:0] lfsrState = 32'h22fa6eab;
	string waveNames[7] = '{"", "Sine", "Cosine", "Triangular", "Sinc", "Sawtooth", "Square"};

	lcdTop #(
		.ePulseCycles(4),
		.eGapCycles(4),
		.clearWaitCycles(12)
	) lcdTop_inst (
		.clk_1MHz(clk_1MHz),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.lcdData(lcdData),
		.lcdRs(lcdRs),
		.lcdE(lcdE)
	);

	initial begin
		clk_1MHz = 1'b0;
		forever #2 clk_1MHz = ~clk_1MHz; // 4 ns period
	end

	always @(posedge clk_1MHz) begin
		cycles++;
		if (cycles >= 20000) begin
			$display("Timeout: the run went past 20000 cycles without finishing");
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Galois LFSR, one step per bit
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic randBits(input int n, output logic [31:0] val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val = {val[30:0], lfsrState[0]};
		end
	endtask

	task automatic randDigit(output logic [7:0] d);
		logic [31:0] r;
		randBits(4, r);
		d = 8'h30 + 8'(r % 10); // ascii 0 to 9
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
		@(negedge clk_1MHz);
		psel = 1'b1; // setup
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk_1MHz);
		penable = 1'b1; // access
		#1;
		checkValue("pready", 32'(pready), 1);
		err = pslverr;
		@(negedge clk_1MHz);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge clk_1MHz);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk_1MHz);
		penable = 1'b1;
		#1;
		checkValue("pready", 32'(pready), 1);
		data = prdata;
		err = pslverr;
		@(negedge clk_1MHz);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// waits for the next E rise, returns the byte, checks the strobe width
	task automatic captureByte(output logic [7:0] data, output logic rs);
		int width;
		while (lcdE) @(negedge clk_1MHz);
		while (!lcdE) @(negedge clk_1MHz);
		data = lcdData;
		rs = lcdRs;
		width = 0;
		while (lcdE) begin
			width++;
			@(negedge clk_1MHz);
		end
		checkValue("lcdE high cycles", width, 4);
	endtask

	task automatic expectByte(input logic [7:0] exp, input logic expRs);
		logic [7:0] d;
		logic rs;
		captureByte(d, rs);
		checkValue("lcdData", 32'(d), 32'(exp));
		checkValue("lcdRs", 32'(rs), 32'(expRs));
	endtask

	function automatic string padText(input string s, input int lead);
		string r;
		r = "";
		for (int i = 0; i < lead; i++) r = {r, " "};
		r = {r, s};
		while (r.len() < 16) r = {r, " "};
		return r;
	endfunction

	task automatic expectLine(input string txt);
		for (int i = 0; i < 16; i++) expectByte(txt[i], 1'b1);
	endtask

	task automatic expectScreen(input string line1, input string line2);
		expectByte(8'h80, 1'b0);
		expectLine(line1);
		expectByte(8'hC0, 1'b0);
		expectLine(line2);
	endtask

	task automatic testPowerUp();
		expectByte(8'h38, 1'b0);
		expectByte(8'h0C, 1'b0);
		expectByte(8'h06, 1'b0);
		expectByte(8'h01, 1'b0);
		expectScreen(padText("Waveform", 4), padText("Generator!", 3));
		expectScreen(padText("Waveform", 4), padText("Generator!", 3)); // no clear in loop
	endtask

	task automatic testSignalScreen();
		logic err;
		for (int w = 1; w <= 6; w++) begin
			apbWrite(8'h00, (w << 4) | 2, err);
			checkValue("pslverr", 32'(err), 0);
			expectByte(8'h01, 1'b0); // redraw opens with a clear at the next byte
			expectScreen(padText("Selected Signal", 0), padText(waveNames[w], 0));
		end
	endtask

	task automatic testReadout(output logic [31:0] digits);
		logic err;
		logic [7:0] d0;
		logic [7:0] d1;
		logic [7:0] d2;
		randDigit(d0);
		randDigit(d1);
		randDigit(d2);
		digits = {"K", d2, d1, d0};
		apbWrite(8'h04, digits, err);
		checkValue("pslverr", 32'(err), 0);
		apbWrite(8'h00, 32'h65, err); // generating, waveSel 6 is ignored here
		checkValue("pslverr", 32'(err), 0);
		expectByte(8'h01, 1'b0);
		expectScreen(padText("Generating...", 0),
			padText($sformatf("%c%c%c KHz", d0, d1, d2), 0));
	endtask

	task automatic testRegisters(input logic [31:0] digits);
		logic [31:0] rd;
		logic err;
		apbRead(8'h00, rd, err);
		checkValue("CTRL", rd, 32'h65);
		checkValue("pslverr", 32'(err), 0);
		apbRead(8'h04, rd, err);
		checkValue("DIGITS", rd, digits);
		apbWrite(8'h08, 32'hffff_ffff, err);
		checkValue("pslverr", 32'(err), 1);
		apbRead(8'h08, rd, err);
		checkValue("prdata offset 8", rd, 0);
		checkValue("pslverr", 32'(err), 1);
		apbRead(8'h00, rd, err);
		checkValue("CTRL", rd, 32'h65); // untouched by bad write
		apbRead(8'h04, rd, err);
		checkValue("DIGITS", rd, digits);
	endtask

	initial begin
		logic [31:0] digits;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		repeat (10) @(negedge clk_1MHz);
		rstN = 1'b1;
		testPowerUp();
		testSignalScreen();
		testReadout(digits);
		testRegisters(digits);
		if (lcdTop_inst.tbLcdProps_inst.failCount != 0) begin
			$display("A bound assertion on lcdTop failed during the run");
			$display("TEST FAILED");
			$fatal(1);
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
lcdPkg.sv
lcdApbRegs.sv
lcdScreenText.sv
lcdWriteSeq.sv
lcdTop.sv
tbLcdProps.sv
tbLcd.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f filelist.f --top-module tbLcd -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
